//--- sim.f
+incdir+source
source/alu_pkg.sv
source/alu_if.sv
source/alu_adder.sv
source/alu_shifter.sv
source/alu_divider.sv
source/alu_core.sv
source/alu_wb_slave.sv
source/alu_top.sv
test/tb_clock.sv
test/alu_assertions.sv
test/alu_tb.sv

//--- Bender.yml
package:
  name: rv32m_wb_alu

sources:
  - include_dirs:
      - source
    files:
      - source/alu_pkg.sv
      - source/alu_if.sv
      - source/alu_adder.sv
      - source/alu_shifter.sv
      - source/alu_divider.sv
      - source/alu_core.sv
      - source/alu_wb_slave.sv
      - source/alu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_clock.sv
      - test/alu_assertions.sv
      - test/alu_tb.sv

//--- test/alu_tb.sv
`include "alu_defs.svh"

module alu_tb import alu_pkg::*; ();

    localparam word_t MIN_INT  = 32'h8000_0000;
    localparam word_t ALL_ONES = 32'hffff_ffff;
    // ~260 short ops at <= 20 cycles, ~50 divides at <= 60 cycles
    localparam int TIMEOUT_CYCLES = 260 * 20 + 50 * 60;

    logic       clk;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [4:0] wb_adr;
    word_t      wb_dat_w;
    logic [3:0] wb_sel;
    word_t      wb_dat_r;
    logic       wb_ack;

    int errors;
    int checks;
    int cycles;
    int seed;
    int result_wait; // ack wait of the last RESULT read

    tb_clock u_clock (.clk(clk));

    alu_top DUT (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // reference behavior per RV32IM
    function automatic word_t model_result(input alu_ctr_t ctr, input word_t a, input word_t b);
        logic [63:0] sprod;
        logic [63:0] uprod;
        logic        ovf;
        word_t       r;
        sprod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        uprod = {32'd0, a} * {32'd0, b};
        ovf   = (a == MIN_INT) && (b == ALL_ONES); // signed overflow case
        r     = '0;                                // undefined codes
        case (ctr)
            5'b00000: r = a + b;
            5'b10000: r = a - b;
            5'b00001: r = a << b[4:0];
            5'b00010: r = ($signed(a) < $signed(b)) ? ALL_ONES : '0;
            5'b00011: r = (a < b) ? ALL_ONES : '0;
            5'b11000: r = b;
            5'b00100: r = a ^ b;
            5'b00101: r = a >> b[4:0];
            5'b10101: r = $signed(a) >>> b[4:0];
            5'b00110: r = a | b;
            5'b00111: r = a & b;
            5'b01000: r = sprod[31:0];
            5'b01001: r = sprod[63:32];
            5'b01011: r = uprod[63:32];
            5'b01100: begin
                if (b == '0) r = ALL_ONES;
                else if (ovf) r = a;
                else r = $signed(a) / $signed(b); // truncates toward zero
            end
            5'b01101: r = (b == '0) ? ALL_ONES : a / b;
            5'b01110: begin
                if (b == '0) r = a;
                else if (ovf) r = '0;
                else r = $signed(a) % $signed(b); // sign of dividend
            end
            5'b01111: r = (b == '0) ? a : a % b;
            default: r = '0;
        endcase
        return r;
    endfunction

    // one classic cycle, waits for ack, then drops stb for a cycle
    task automatic bus_cycle(input logic we, input reg_idx_t idx, input word_t wdata,
                             output word_t rdata, output int waited);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= {idx, 2'b00};
        wb_dat_w <= wdata;
        waited = 0;
        do begin
            @(negedge clk); // ack and data stable here
            waited++;
        end while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_reg(input reg_idx_t idx, input word_t data);
        word_t unused;
        int    waited;
        bus_cycle(1'b1, idx, data, unused, waited);
    endtask

    task automatic read_reg(input reg_idx_t idx, output word_t data);
        int waited;
        bus_cycle(1'b0, idx, '0, data, waited);
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s: got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    // load operands, launch, read RESULT straight away
    task automatic check_op(input alu_ctr_t ctr, input word_t a, input word_t b);
        word_t res;
        write_reg(`ALU_REG_A, a);
        write_reg(`ALU_REG_B, b);
        write_reg(`ALU_REG_CTRL, {27'd0, ctr});
        bus_cycle(1'b0, `ALU_REG_RESULT, '0, res, result_wait); // held while busy
        check_value($sformatf("ctr %05b a %08h b %08h", ctr, a, b), res,
                    model_result(ctr, a, b));
    endtask

    // adder flags after sub, slt or sltu
    task automatic check_flags(input alu_ctr_t ctr, input word_t a, input word_t b);
        word_t flags;
        word_t diff;
        logic  less;
        diff = a - b;
        less = (ctr == 5'b00011) ? (a < b) : ($signed(a) < $signed(b));
        read_reg(`ALU_REG_FLAGS, flags);
        check_value($sformatf("flags ctr %05b a %08h b %08h", ctr, a, b), flags,
                    {29'd0, 1'b0, diff == '0, less}); // busy low by now
    endtask

    task automatic register_access();
        word_t data;
        word_t va;
        word_t vb;
        for (int i = 0; i < 5; i++) begin
            read_reg(reg_idx_t'(i), data);
            check_value($sformatf("reset value of register %0d", i), data, '0);
        end
        va = $random(seed);
        vb = $random(seed);
        write_reg(`ALU_REG_A, va);
        write_reg(`ALU_REG_B, vb);
        read_reg(`ALU_REG_A, data);
        check_value("A readback", data, va);
        read_reg(`ALU_REG_B, data);
        check_value("B readback", data, vb);
    endtask

    task automatic integer_ops();
        alu_ctr_t codes [9];
        codes = '{5'b00000, 5'b10000, 5'b00100, 5'b00110, 5'b00111,
                  5'b11000, 5'b00001, 5'b00101, 5'b10101};
        foreach (codes[k]) begin
            for (int i = 0; i < 20; i++) begin
                check_op(codes[k], $random(seed), $random(seed)); // b mostly > 31
            end
        end
        check_op(5'b00001, 32'h0000_0001, 32'h0000_0021); // shift by 33 acts as 1
    endtask

    task automatic compare_ops();
        alu_ctr_t codes [3];
        word_t    a;
        word_t    b;
        codes = '{5'b10000, 5'b00010, 5'b00011};
        foreach (codes[k]) begin
            for (int i = 0; i < 9; i++) begin
                a = $random(seed);
                b = $random(seed);
                case (i)
                    0: b = a; // equal
                    1: begin // neg vs pos
                        a = a | MIN_INT;
                        b = b & ~MIN_INT;
                    end
                    2: begin
                        a = a & ~MIN_INT;
                        b = b | MIN_INT;
                    end
                    3: begin
                        a = MIN_INT;
                        b = 32'h7fff_ffff;
                    end
                    default: ;
                endcase
                check_op(codes[k], a, b);
                check_flags(codes[k], a, b);
            end
        end
    endtask

    task automatic multiply_ops();
        alu_ctr_t codes [3];
        codes = '{5'b01000, 5'b01001, 5'b01011};
        foreach (codes[k]) begin
            check_op(codes[k], MIN_INT, MIN_INT);
            check_op(codes[k], MIN_INT, ALL_ONES);
            check_op(codes[k], MIN_INT, $random(seed));
            for (int i = 0; i < 8; i++) begin
                check_op(codes[k], $random(seed), $random(seed));
            end
        end
    endtask

    task automatic divide_ops();
        alu_ctr_t codes [4];
        word_t    b;
        codes = '{5'b01100, 5'b01101, 5'b01110, 5'b01111};
        foreach (codes[k]) begin
            check_op(codes[k], $random(seed), '0);      // divide by zero
            check_op(codes[k], MIN_INT, ALL_ONES);      // signed overflow
            check_op(codes[k], 32'hffff_ff9c, 32'd7);   // -100 by 7
            for (int i = 0; i < 8; i++) begin
                b = $random(seed);
                b = $signed(b) >>> (i * 3);              // spread of divisor sizes
                check_op(codes[k], $random(seed), b);
            end
            // RESULT read issued right after launch must have waited for the divider
            if (result_wait < `ALU_DIV_CYCLES / 2) begin
                errors++;
                $display("[ERROR] t=%0t RESULT read was acked after %0d cycles, before the",
                         $time, result_wait);
                $display("        division could have finished");
            end
        end
    endtask

    task automatic undefined_and_stall();
        word_t data;
        word_t a;
        word_t b;
        int    waited;
        a = $random(seed);
        b = $random(seed) | 32'h1; // nonzero divisor
        check_op(5'b01010, a, b);  // mulhsu not built
        check_op(5'b11111, a, b);
        write_reg(`ALU_REG_CTRL, 32'hffff_ffea); // only low five bits kept
        read_reg(`ALU_REG_RESULT, data);
        check_value("RESULT of code 01010", data, '0);
        read_reg(`ALU_REG_CTRL, data);
        check_value("CTRL readback", data, 32'h0000_000a);

        write_reg(`ALU_REG_A, a);
        write_reg(`ALU_REG_B, b);
        write_reg(`ALU_REG_CTRL, 32'h0000_000c); // div
        read_reg(`ALU_REG_FLAGS, data);
        check_value("FLAGS busy during division", data & 32'h4, 32'h4);
        bus_cycle(1'b1, `ALU_REG_CTRL, 32'h0000_0000, data, waited); // add held off by div
        if (waited < `ALU_DIV_CYCLES / 2) begin
            errors++;
            $display("[ERROR] t=%0t CTRL write during division was acked after %0d cycles",
                     $time, waited);
        end
        read_reg(`ALU_REG_RESULT, data);
        check_value("add after stalled launch", data, model_result(5'b00000, a, b));
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timed out after %0d cycles, the tests did not finish", cycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        seed     = 32'h0b84b710;
        errors   = 0;
        checks   = 0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = 4'hf; // full word only
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        register_access();
        integer_ops();
        compare_ops();
        multiply_ops();
        divide_ops();
        undefined_and_stall();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- test/alu_assertions.sv
`include "alu_defs.svh"

// one copy on the bus slave, one on the core
module alu_assertions (
    input logic clk,
    input logic rst,
    input logic ack,
    input logic start,
    input logic busy,
    input logic div_start,
    input logic div_done
);

    // ack is a single pulse per access
    ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("wb_ack stayed high for two cycles");

    // launch only into an idle core
    start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("start pulsed while core busy");

    div_latency: assert property (@(posedge clk) disable iff (rst)
        div_start |-> ##`ALU_DIV_CYCLES div_done)
        else $error("divider done missing at fixed latency");

    // no stray done without a matching start
    div_no_stray: assert property (@(posedge clk) disable iff (rst)
        div_done |-> $past(div_start, `ALU_DIV_CYCLES))
        else $error("divider done without start");

endmodule

bind alu_wb_slave alu_assertions u_bus_checks (
    .clk       (clk),
    .rst       (rst),
    .ack       (wb_ack),
    .start     (start_q),
    .busy      (op.busy),
    .div_start (1'b0),   // divider not visible here
    .div_done  (1'b0)
);

bind alu_core alu_assertions u_div_checks (
    .clk       (clk),
    .rst       (rst),
    .ack       (1'b0),
    .start     (op.start), // launch as the core sees it
    .busy      (busy_q),
    .div_start (div_bus.start),
    .div_done  (div_bus.done)
);

//--- test/tb_clock.sv
// free running testbench clock
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk; // 50/50 duty
    end

endmodule

//--- source/alu_top.sv
module alu_top import alu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [4:0] wb_adr,
    input  word_t      wb_dat_w,
    input  logic [3:0] wb_sel,
    output word_t      wb_dat_r,
    output logic       wb_ack
);

    alu_op_if op_bus ();

    // register block, owns the operands
    alu_wb_slave u_slave (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .op       (op_bus)
    );

    // datapath plus divider
    alu_core u_core (
        .clk (clk),
        .rst (rst),
        .op  (op_bus)
    );

endmodule

//--- source/alu_wb_slave.sv
`include "alu_defs.svh"

module alu_wb_slave import alu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [4:0] wb_adr,
    input  word_t      wb_dat_w,
    input  logic [3:0] wb_sel,   // full-word access only, lanes not decoded
    output word_t      wb_dat_r,
    output logic       wb_ack,
    alu_op_if.host     op
);

    word_t    reg_a;
    word_t    reg_b;
    alu_ctr_t reg_ctr;
    logic     start_q;
    reg_idx_t idx;
    logic     req;
    logic     pending;
    logic     hold;

    assign idx = wb_adr[4:2];
    assign req = wb_cyc & wb_stb & ~wb_ack; // no second ack while stb still high

    // core busy, or launch already on its way
    assign pending = op.busy | start_q;

    // back-pressure on result read and on a second launch
    assign hold = pending & ((~wb_we & (idx == `ALU_REG_RESULT))
                           | (wb_we & (idx == `ALU_REG_CTRL)));

    assign op.a     = reg_a;
    assign op.b     = reg_b;
    assign op.ctr   = reg_ctr;
    assign op.start = start_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_a    <= '0;
            reg_b    <= '0;
            reg_ctr  <= '0;
            start_q  <= 1'b0;
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
        end else begin
            wb_ack  <= 1'b0; // single cycle pulses
            start_q <= 1'b0;
            if (req && !hold) begin
                wb_ack <= 1'b1;
                if (wb_we) begin
                    case (idx)
                        `ALU_REG_A: reg_a <= wb_dat_w;
                        `ALU_REG_B: reg_b <= wb_dat_w;
                        `ALU_REG_CTRL: begin
                            reg_ctr <= wb_dat_w[4:0];
                            start_q <= 1'b1; // launch
                        end
                        default: ; // result, flags read only
                    endcase
                end else begin
                    case (idx)
                        `ALU_REG_A: wb_dat_r <= reg_a;
                        `ALU_REG_B: wb_dat_r <= reg_b;
                        `ALU_REG_CTRL: wb_dat_r <= {{(`ALU_XLEN-5){1'b0}}, reg_ctr};
                        `ALU_REG_RESULT: wb_dat_r <= op.result;
                        `ALU_REG_FLAGS: wb_dat_r <= {{(`ALU_XLEN-3){1'b0}}, op.busy, op.zero, op.less};
                        default: wb_dat_r <= '0; // unmapped
                    endcase
                end
            end
        end
    end

endmodule

//--- source/alu_core.sv
`include "alu_defs.svh"

module alu_core import alu_pkg::*; (
    input logic clk,
    input logic rst,
    alu_op_if.unit op
);

    localparam int MSB = `ALU_XLEN - 1;

    core_state_e state;
    logic        busy_q;
    word_t       a_q;
    word_t       b_q;
    alu_ctr_t    ctr_q;
    word_t       result_q;
    logic        less_q;
    logic        zero_q;

    logic  sub;
    logic  is_unsigned;
    logic  left;
    logic  arith;
    logic  is_div;
    logic  mul_signed;
    word_t sum;
    word_t shift_out;
    word_t alu_out;
    logic  add_less;
    logic  add_zero;

    logic [2*`ALU_XLEN-1:0] mul_a;
    logic [2*`ALU_XLEN-1:0] mul_b;
    logic [2*`ALU_XLEN-1:0] mul_full;

    div_if div_bus ();

    // control decode from the latched code
    assign sub         = (ctr_q == 5'b10000) | (ctr_q == 5'b00010) | (ctr_q == 5'b00011);
    assign is_unsigned = (ctr_q == 5'b00011); // sltu
    assign left        = (ctr_q[2:0] == 3'b001);
    assign arith       = (ctr_q[4:3] == 2'b10);
    assign is_div      = (ctr_q[4:2] == 3'b011); // div, divu, rem, remu
    assign mul_signed  = (ctr_q == 5'b01001);    // mulh only

    alu_adder u_adder (
        .a           (a_q),
        .b           (b_q),
        .sub         (sub),
        .is_unsigned (is_unsigned),
        .sum         (sum),
        .zero        (add_zero),
        .less        (add_less)
    );

    alu_shifter u_shifter (
        .din   (a_q),
        .shamt (b_q[4:0]), // upper bits ignored
        .left  (left),
        .arith (arith),
        .dout  (shift_out)
    );

    alu_divider u_divider (
        .clk (clk),
        .rst (rst),
        .div (div_bus)
    );

    // divider launched the cycle after op.start
    assign div_bus.dividend  = a_q;
    assign div_bus.divisor   = b_q;
    assign div_bus.is_signed = ~ctr_q[0];
    assign div_bus.start     = (state == IDLE) & busy_q & is_div;

    // 64 bit product, low half is the same either way
    assign mul_a    = {{`ALU_XLEN{mul_signed & a_q[MSB]}}, a_q};
    assign mul_b    = {{`ALU_XLEN{mul_signed & b_q[MSB]}}, b_q};
    assign mul_full = mul_a * mul_b;

    always_comb begin
        case (ctr_q)
            5'b00000, 5'b10000: alu_out = sum;
            5'b00001, 5'b00101, 5'b10101: alu_out = shift_out;
            5'b00010, 5'b00011: alu_out = {`ALU_XLEN{add_less}};
            5'b11000: alu_out = b_q;
            5'b00100: alu_out = a_q ^ b_q;
            5'b00110: alu_out = a_q | b_q;
            5'b00111: alu_out = a_q & b_q;
            5'b01000: alu_out = mul_full[MSB:0];
            5'b01001, 5'b01011: alu_out = mul_full[2*`ALU_XLEN-1:`ALU_XLEN];
            default: alu_out = '0; // div codes come from the divider
        endcase
    end

    // operand latch
    always_ff @(posedge clk) begin
        if (op.start && !busy_q) begin
            a_q   <= op.a;
            b_q   <= op.b;
            ctr_q <= op.ctr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            busy_q   <= 1'b0;
            result_q <= '0;
            less_q   <= 1'b0;
            zero_q   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (op.start && !busy_q) begin
                        busy_q <= 1'b1;
                    end else if (busy_q) begin
                        if (is_div) begin
                            state <= DIVIDING; // div_bus.start high this cycle
                        end else begin
                            result_q <= alu_out;
                            less_q   <= add_less;
                            zero_q   <= add_zero;
                            busy_q   <= 1'b0;
                        end
                    end
                end
                DIVIDING: begin
                    if (div_bus.done) begin
                        result_q <= ctr_q[1] ? div_bus.remainder : div_bus.quotient;
                        less_q   <= add_less;
                        zero_q   <= add_zero;
                        busy_q   <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign op.result = result_q;
    assign op.less   = less_q;
    assign op.zero   = zero_q;
    assign op.busy   = busy_q;

endmodule

//--- source/alu_divider.sv
`include "alu_defs.svh"

module alu_divider import alu_pkg::*; (
    input logic clk,
    input logic rst,
    div_if.resp div
);

    localparam int MSB = `ALU_XLEN - 1;

    div_state_e state;
    logic [4:0] step_cnt;

    word_t quo;      // dividend shifts out, quotient bits shift in
    word_t rem;      // partial remainder
    word_t dsr;      // divisor magnitude
    logic  neg_q;
    logic  neg_r;
    logic  special;  // div by zero or overflow, result preloaded

    word_t abs_dividend;
    word_t abs_divisor;
    logic  div_zero;
    logic  div_ovf;

    logic [`ALU_XLEN:0]   shifted;
    logic [`ALU_XLEN+1:0] trial;

    // magnitudes for signed ops
    assign abs_dividend = (div.is_signed && div.dividend[MSB]) ? -div.dividend : div.dividend;
    assign abs_divisor  = (div.is_signed && div.divisor[MSB]) ? -div.divisor : div.divisor;

    assign div_zero = (div.divisor == '0);
    // most negative / -1
    assign div_ovf  = div.is_signed && (div.dividend == {1'b1, {MSB{1'b0}}})
                      && (div.divisor == '1);

    // one restoring step: shift in next dividend bit, trial subtract
    assign shifted = {rem, quo[MSB]};
    assign trial   = {1'b0, shifted} - {2'b00, dsr};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= D_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    step_cnt <= '0;
                    if (div.start) state <= D_RUN;
                end
                D_RUN: begin
                    step_cnt <= step_cnt + 5'd1;
                    if (step_cnt == 5'(`ALU_DIV_CYCLES - 2)) state <= D_FIX; // last step
                end
                default: state <= D_IDLE; // D_FIX lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == D_IDLE && div.start) begin
            dsr     <= abs_divisor;
            special <= div_zero | div_ovf;
            if (div_zero) begin
                quo   <= '1;            // all ones
                rem   <= div.dividend;  // dividend unchanged
                neg_q <= 1'b0;
                neg_r <= 1'b0;
            end else if (div_ovf) begin
                quo   <= div.dividend;
                rem   <= '0;
                neg_q <= 1'b0;
                neg_r <= 1'b0;
            end else begin
                quo   <= abs_dividend;
                rem   <= '0;
                neg_q <= div.is_signed & (div.dividend[MSB] ^ div.divisor[MSB]);
                neg_r <= div.is_signed & div.dividend[MSB]; // remainder follows dividend
            end
        end else if (state == D_RUN && !special) begin
            quo <= {quo[MSB-1:0], ~trial[`ALU_XLEN+1]};
            if (trial[`ALU_XLEN+1]) begin
                rem <= shifted[MSB:0]; // negative, restore
            end else begin
                rem <= trial[MSB:0];
            end
        end
    end

    // sign fix, stable from D_FIX until the next start
    assign div.quotient  = neg_q ? -quo : quo;
    assign div.remainder = neg_r ? -rem : rem;
    assign div.done      = (state == D_FIX);

endmodule

//--- source/alu_shifter.sv
`include "alu_defs.svh"

module alu_shifter import alu_pkg::*; (
    input  word_t      din,
    input  logic [4:0] shamt,
    input  logic       left,   // 1 = sll
    input  logic       arith,  // sign fill on right shift
    output word_t      dout
);

    localparam int MSB = `ALU_XLEN - 1;

    word_t stage [0:5];
    logic  fill;

    function automatic word_t bit_rev(input word_t v);
        word_t r;
        for (int i = 0; i < `ALU_XLEN; i++) begin
            r[i] = v[MSB-i];
        end
        return r;
    endfunction

    // left shift = reverse, shift right, reverse back
    assign stage[0] = left ? bit_rev(din) : din;
    assign fill     = arith & ~left & din[MSB]; // never sign fill on sll

    // one stage per shamt bit, 1/2/4/8/16
    for (genvar k = 0; k < 5; k++) begin : g_stage
        assign stage[k+1] = shamt[k] ? {{(2**k){fill}}, stage[k][MSB:2**k]} : stage[k];
    end

    assign dout = left ? bit_rev(stage[5]) : stage[5];

endmodule

//--- source/alu_adder.sv
`include "alu_defs.svh"

module alu_adder import alu_pkg::*; (
    input  word_t a,
    input  word_t b,
    input  logic  sub,          // 1 = a - b
    input  logic  is_unsigned,  // less from carry instead of sign
    output word_t sum,
    output logic  zero,
    output logic  less
);

    localparam int MSB = `ALU_XLEN - 1;

    word_t b_eff;
    logic  carry;
    logic  overflow;

    // two's complement subtract: invert b, carry in = 1
    assign b_eff = b ^ {`ALU_XLEN{sub}};
    assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{`ALU_XLEN{1'b0}}, sub};

    // same operand signs but result sign flipped
    assign overflow = (a[MSB] == b_eff[MSB]) && (sum[MSB] != a[MSB]);
    assign zero     = (sum == '0);

    // borrow for unsigned, sign corrected by overflow for signed
    assign less = is_unsigned ? (carry ^ sub) : (overflow ^ sum[MSB]);

endmodule

//--- source/alu_if.sv
// operand/result handshake between bus slave and core
interface alu_op_if import alu_pkg::*; ();
    word_t    a;
    word_t    b;
    alu_ctr_t ctr;
    logic     start;  // one cycle, only while busy low
    word_t    result;
    logic     less;
    logic     zero;
    logic     busy;   // rises on start, falls with valid result

    modport host (
        output a, b, ctr, start,
        input  result, less, zero, busy
    );

    modport unit (
        input  a, b, ctr, start,
        output result, less, zero, busy
    );
endinterface

// core to divider request and response
interface div_if import alu_pkg::*; ();
    word_t dividend;
    word_t divisor;
    logic  is_signed;
    logic  start;
    word_t quotient;  // held until next start
    word_t remainder;
    logic  done;      // one cycle pulse, fixed latency

    modport req (
        output dividend, divisor, is_signed, start,
        input  quotient, remainder, done
    );

    modport resp (
        input  dividend, divisor, is_signed, start,
        output quotient, remainder, done
    );
endinterface

//--- source/alu_pkg.sv
`include "alu_defs.svh"

package alu_pkg;

    // one data word
    typedef logic [`ALU_XLEN-1:0] word_t;

    // control code {funct7[5], funct7[0], funct3}
    // 00000 add     10000 sub     00001 sll     00010 slt
    // 00011 sltu    11000 pass b  00100 xor     00101 srl
    // 10101 sra     00110 or      00111 and
    // 01000 mul     01001 mulh    01011 mulhu
    // 01100 div     01101 divu    01110 rem     01111 remu
    typedef logic [4:0] alu_ctr_t;

    // register word index
    typedef logic [2:0] reg_idx_t;

    // core sequencing
    typedef enum logic {
        IDLE,
        DIVIDING
    } core_state_e;

    // divider sequencing
    typedef enum logic [1:0] {
        D_IDLE,
        D_RUN,  // 32 restoring steps
        D_FIX   // signed result presented, done high
    } div_state_e;

endpackage

//--- source/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// datapath width, one RV32 word
`define ALU_XLEN 32

// start to done of the restoring divider
// 32 shift/subtract steps plus the sign fix
`define ALU_DIV_CYCLES 33

// word offsets, decoded from wb_adr[4:2]
`define ALU_REG_A      3'd0
`define ALU_REG_B      3'd1
`define ALU_REG_CTRL   3'd2
`define ALU_REG_RESULT 3'd3 // read only
`define ALU_REG_FLAGS  3'd4 // read only, {busy, zero, less}

`endif
